// ==== list.f ====
bridge_ram_pkg.sv
bridge_synch.sv
bridge_word_sequencer.sv
word_ram_ctrl.sv
bridge_ram_top.sv
bridge_ram_asserts.sv
tb_bridge_ram.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the bridge to word RAM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_bridge_ram -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed (exit status $status)"
	exit 1
fi

// ==== tb_bridge_ram.sv ====
/*
 * Testbench for the bridge to word RAM path: bridge accesses in both
 * endian modes, random traffic and the reserved register window
 */

`timescale 1ns/1ps

module tb_bridge_ram
	import bridge_ram_pkg::*;
();

	// 60 accesses of at most 120 clk_sys cycles each
	localparam int WATCHDOG_NS = 60 * 120 * 20;

	logic         clk_74a;
	logic         clk_sys;
	logic         reset_l;
	logic         big_endian;
	bridge_addr_t bridge_addr;
	logic         bridge_rd;
	logic         bridge_wr;
	bridge_data_t bridge_wr_data;
	bridge_data_t bridge_rd_data;
	logic         bridge_processing;
	logic         bridge_completed;

	// Expected contents per 32-bit word in big-endian form
	bridge_data_t shadow [0:511];
	integer       seed;

	bridge_ram_top #(.RAM_LATENCY(3), .RAM_WORDS_LOG2(10)) DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Starts high so its falling edges stay clear of rising clk_sys edges
	initial begin
		clk_74a = 1'b1;
		forever #13.5 clk_74a = ~clk_74a;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		report_failure();
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Bytes swapped within each half-word
	function automatic bridge_data_t swap_halves(input bridge_data_t v);
		return {v[23:16], v[31:24], v[7:0], v[15:8]};
	endfunction

	function automatic bridge_addr_t rand_addr();
		bridge_data_t r;
		r = $random(seed);
		return {22'd0, r[9:2], 2'b00};
	endfunction

	task automatic report_failure();
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic drive_strobe(input logic is_write, input bridge_addr_t addr,
		input bridge_data_t data);
		@(negedge clk_74a);
		bridge_addr    = addr;
		bridge_wr_data = data;
		bridge_wr      = is_write;
		bridge_rd      = !is_write;
		repeat (6) @(negedge clk_74a);
		bridge_wr = 1'b0;
		bridge_rd = 1'b0;
	endtask

	task automatic bridge_access(input logic is_write, input bridge_addr_t addr,
		input bridge_data_t data);
		int waited;
		drive_strobe(is_write, addr, data);
		waited = 0;
		@(negedge clk_sys);
		while (!bridge_completed && waited < 100) begin
			@(negedge clk_sys);
			waited++;
		end
		assert (bridge_completed === 1'b1) else begin
			$display("No completion within 100 cycles for the access at address %h", addr);
			report_failure();
		end
		// Processing drops in the completion cycle itself
		assert (bridge_processing === 1'b0) else begin
			$display("Mismatch at %0t ns: bridge_processing actual %b expected 0",
				$time, bridge_processing);
			report_failure();
		end
	endtask

	task automatic write_word(input bridge_addr_t addr, input bridge_data_t data);
		bridge_access(1'b1, addr, data);
		shadow[addr[10:2]] = big_endian ? data : swap_halves(data);
	endtask

	task automatic read_check(input bridge_addr_t addr);
		bridge_data_t expected;
		expected = big_endian ? shadow[addr[10:2]] : swap_halves(shadow[addr[10:2]]);
		bridge_access(1'b0, addr, '0);
		assert (bridge_rd_data === expected) else begin
			$display("Mismatch at %0t ns: bridge_rd_data actual %h expected %h",
				$time, bridge_rd_data, expected);
			report_failure();
		end
	endtask

	task automatic check_reset_outputs();
		assert (bridge_processing === 1'b0) else begin
			$display("Mismatch at %0t ns: bridge_processing actual %b expected 0",
				$time, bridge_processing);
			report_failure();
		end
		assert (bridge_completed === 1'b0) else begin
			$display("Mismatch at %0t ns: bridge_completed actual %b expected 0",
				$time, bridge_completed);
			report_failure();
		end
		assert (bridge_rd_data === '0) else begin
			$display("Mismatch at %0t ns: bridge_rd_data actual %h expected 0",
				$time, bridge_rd_data);
			report_failure();
		end
	endtask

	// Register window access must never reach the sequencer
	task automatic reserved_access(input logic is_write, input bridge_addr_t addr,
		input bridge_data_t data);
		drive_strobe(is_write, {RESERVED_WINDOW, addr[23:0]}, data);
		repeat (40) begin
			@(negedge clk_sys);
			assert (bridge_processing === 1'b0) else begin
				$display("Mismatch at %0t ns: bridge_processing actual %b expected 0",
					$time, bridge_processing);
				report_failure();
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		bridge_addr_t addr_q[$];
		bridge_addr_t tmp;
		int           j;
		seed           = 22;
		reset_l        = 1'b0;
		big_endian     = 1'b1;
		bridge_addr    = '0;
		bridge_rd      = 1'b0;
		bridge_wr      = 1'b0;
		bridge_wr_data = '0;

		repeat (2) @(negedge clk_sys);
		check_reset_outputs();
		repeat (2) @(negedge clk_sys);
		reset_l = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_reset_outputs();

		write_word(32'h0000_0040, 32'h1234_5678);
		read_check(32'h0000_0040);

		// Little-endian round trip, then the same word seen big-endian
		@(negedge clk_sys);
		big_endian = 1'b0;
		write_word(32'h0000_0080, 32'hA1B2_C3D4);
		read_check(32'h0000_0080);
		@(negedge clk_sys);
		big_endian = 1'b1;
		read_check(32'h0000_0080);

		for (int i = 0; i < 20; i++) begin
			addr_q.push_back(rand_addr());
			write_word(addr_q[i], $random(seed));
		end
		for (int i = 19; i > 0; i--) begin
			j = {$random(seed)} % (i + 1);
			tmp = addr_q[i];
			addr_q[i] = addr_q[j];
			addr_q[j] = tmp;
		end
		foreach (addr_q[i]) begin
			read_check(addr_q[i]);
		end

		// Word at A+4 keeps its value across a write to A
		tmp = rand_addr();
		write_word(tmp + 32'd4, 32'h5A5A_0F0F);
		write_word(tmp, 32'hC0DE_1234);
		read_check(tmp + 32'd4);
		read_check(tmp);

		reserved_access(1'b1, tmp, 32'hDEAD_BEEF);
		reserved_access(1'b0, tmp, '0);
		read_check(tmp);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== bridge_ram_asserts.sv ====
/*
 * Bound checks on the word RAM port and the bridge status outputs
 */

`timescale 1ns/1ps

module bridge_ram_asserts (
	input logic clk_sys,
	input logic reset_l,
	input logic word_rd,
	input logic word_wr,
	input logic word_busy,
	input logic bridge_processing,
	input logic bridge_completed
);

	// One RAM command at a time
	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!reset_l)
		!(word_rd && word_wr))
		else $error("word_rd and word_wr high together");

	// Commands leave the sequencer only after it saw the RAM idle
	no_issue_when_busy: assert property (@(posedge clk_sys) disable iff (!reset_l)
		(word_rd || word_wr) |-> !$past(word_busy))
		else $error("RAM command issued while word_busy was high");

	completed_after_processing: assert property (@(posedge clk_sys) disable iff (!reset_l)
		bridge_completed |-> $past(bridge_processing))
		else $error("bridge_completed without bridge_processing in the previous cycle");

	// RAM traffic belongs to an accepted bridge access
	command_inside_access: assert property (@(posedge clk_sys) disable iff (!reset_l)
		(word_rd || word_wr) |-> bridge_processing)
		else $error("RAM command while bridge_processing is low");

endmodule

bind bridge_word_sequencer bridge_ram_asserts u_asserts (
	.clk_sys           (clk_sys),
	.reset_l           (reset_l),
	.word_rd           (word_rd),
	.word_wr           (word_wr),
	.word_busy         (word_busy),
	.bridge_processing (bridge_processing),
	.bridge_completed  (bridge_completed)
);

// ==== bridge_ram_top.sv ====
/*
 * Bridge to word RAM top level: synchronizers from the bridge domain,
 * word sequencer and RAM controller
 */

`timescale 1ns/1ps

module bridge_ram_top
	import bridge_ram_pkg::*;
#(
	parameter int RAM_LATENCY    = 3,
	parameter int RAM_WORDS_LOG2 = 10
) (
	// Bridge clock, only the inputs below are launched from it
	input  logic         clk_74a,
	input  logic         clk_sys,
	input  logic         reset_l,
	input  logic         big_endian,

	input  bridge_addr_t bridge_addr,
	input  logic         bridge_rd,
	input  logic         bridge_wr,
	input  bridge_data_t bridge_wr_data,
	output bridge_data_t bridge_rd_data,
	output logic         bridge_processing,
	output logic         bridge_completed
);

	logic         rd_fall;
	logic         wr_fall;
	bridge_addr_t addr_s;
	bridge_data_t wr_data_s;

	logic         word_rd;
	logic         word_wr;
	word_addr_t   word_addr;
	word_data_t   word_data;
	word_data_t   word_q;
	logic         word_busy;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bridge domain into clk_sys
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Strobes, only the falling edge starts an access
	bridge_synch #(.WIDTH(1)) u_synch_rd (
		.clk_sys (clk_sys),
		.reset_l (reset_l),
		.d       (bridge_rd),
		.q       (),
		.rise    (),
		.fall    (rd_fall)
	);

	bridge_synch #(.WIDTH(1)) u_synch_wr (
		.clk_sys (clk_sys),
		.reset_l (reset_l),
		.d       (bridge_wr),
		.q       (),
		.rise    (),
		.fall    (wr_fall)
	);

	// Address and data are stable well before the strobe falls
	bridge_synch #(.WIDTH(32)) u_synch_addr (
		.clk_sys (clk_sys),
		.reset_l (reset_l),
		.d       (bridge_addr),
		.q       (addr_s),
		.rise    (),
		.fall    ()
	);

	bridge_synch #(.WIDTH(32)) u_synch_data (
		.clk_sys (clk_sys),
		.reset_l (reset_l),
		.d       (bridge_wr_data),
		.q       (wr_data_s),
		.rise    (),
		.fall    ()
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequencer and RAM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	bridge_word_sequencer u_seq (
		.clk_sys           (clk_sys),
		.reset_l           (reset_l),
		.big_endian        (big_endian),
		.bridge_addr       (addr_s),
		.bridge_wr_data    (wr_data_s),
		.bridge_rd_fall    (rd_fall),
		.bridge_wr_fall    (wr_fall),
		.bridge_rd_data    (bridge_rd_data),
		.bridge_processing (bridge_processing),
		.bridge_completed  (bridge_completed),
		.word_rd           (word_rd),
		.word_wr           (word_wr),
		.word_addr         (word_addr),
		.word_data         (word_data),
		.word_q            (word_q),
		.word_busy         (word_busy)
	);

	word_ram_ctrl #(
		.RAM_LATENCY    (RAM_LATENCY),
		.RAM_WORDS_LOG2 (RAM_WORDS_LOG2)
	) u_ram (
		.clk_sys   (clk_sys),
		.reset_l   (reset_l),
		.word_rd   (word_rd),
		.word_wr   (word_wr),
		.word_addr (word_addr),
		.word_data (word_data),
		.word_q    (word_q),
		.word_busy (word_busy)
	);

endmodule

// ==== word_ram_ctrl.sv ====
/*
 * Word RAM controller model: 16-bit storage with a busy window
 * of fixed latency per access and registered read data
 */

`timescale 1ns/1ps

module word_ram_ctrl
	import bridge_ram_pkg::*;
#(
	parameter int RAM_LATENCY    = 3,
	parameter int RAM_WORDS_LOG2 = 10
) (
	input  logic       clk_sys,
	input  logic       reset_l,
	input  logic       word_rd,
	input  logic       word_wr,
	input  word_addr_t word_addr,
	input  word_data_t word_data,
	output word_data_t word_q,
	output logic       word_busy
);

	// Latency must be at least one cycle for the countdown to finish an access
	localparam int CNT_W = (RAM_LATENCY > 0) ? $clog2(RAM_LATENCY + 1) : 1;
	localparam int DEPTH = 2 ** RAM_WORDS_LOG2;

	word_data_t mem [0:DEPTH-1];

	logic [CNT_W-1:0]          count;
	logic                      pend_rd;
	logic                      op_done;
	word_addr_t                lat_addr;
	word_data_t                lat_data;
	logic [RAM_WORDS_LOG2-1:0] index;

	// Half-word index, byte address without bit 0
	assign index = lat_addr[RAM_WORDS_LOG2:1];

	// Last busy cycle of the window
	assign op_done = (count == CNT_W'(1));

	// Busy in the pulse cycle and while the counter runs
	assign word_busy = word_rd | word_wr | (count != '0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Latency counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			count   <= '0;
			pend_rd <= 1'b0;
		end else if (word_rd | word_wr) begin
			count   <= CNT_W'(RAM_LATENCY);
			pend_rd <= word_rd;
		end else if (count != '0) begin
			count <= count - CNT_W'(1);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage and read data
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_sys) begin
		if (word_rd | word_wr) begin
			lat_addr <= word_addr;
			lat_data <= word_data;
		end
	end

	// word_q holds until the next read completes
	always_ff @(posedge clk_sys) begin
		if (op_done) begin
			if (pend_rd) begin
				word_q <= mem[index];
			end else begin
				mem[index] <= lat_data;
			end
		end
	end

endmodule

// ==== bridge_word_sequencer.sv ====
/*
 * Bridge word sequencer: splits each 32-bit bridge access into two
 * 16-bit RAM accesses at A and A+2, with byte swap for little-endian cores
 */

`timescale 1ns/1ps

module bridge_word_sequencer
	import bridge_ram_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset_l,
	input  logic         big_endian,

	// Bridge side, already synchronized
	input  bridge_addr_t bridge_addr,
	input  bridge_data_t bridge_wr_data,
	input  logic         bridge_rd_fall,
	input  logic         bridge_wr_fall,
	output bridge_data_t bridge_rd_data,
	output logic         bridge_processing,
	output logic         bridge_completed,

	// Word RAM port
	output logic         word_rd,
	output logic         word_wr,
	output word_addr_t   word_addr,
	output word_data_t   word_data,
	input  word_data_t   word_q,
	input  logic         word_busy
);

	// Swap the two bytes of one half-word
	function automatic word_data_t swap16(input word_data_t w);
		return {w[7:0], w[15:8]};
	endfunction

	seq_state_t   state;
	logic         is_read;
	logic         accept;
	bridge_data_t wr_adjusted;
	bridge_data_t wr_latch;
	word_data_t   q_adjusted;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Acceptance and endian handling
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Register window accesses are left to other logic
	assign accept = (bridge_rd_fall | bridge_wr_fall) &&
		(bridge_addr[31:24] != RESERVED_WINDOW);

	// Little-endian cores see each half-word byte swapped
	assign wr_adjusted = big_endian ? bridge_wr_data :
		{swap16(bridge_wr_data[31:16]), swap16(bridge_wr_data[15:0])};

	assign q_adjusted = big_endian ? word_q : swap16(word_q);

	// Write data held for both halves of the access
	always_ff @(posedge clk_sys) begin
		if (state == seq_idle && accept) begin
			wr_latch <= wr_adjusted;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Access state machine
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			state             <= seq_idle;
			is_read           <= 1'b0;
			word_rd           <= 1'b0;
			word_wr           <= 1'b0;
			word_addr         <= '0;
			word_data         <= '0;
			bridge_rd_data    <= '0;
			bridge_processing <= 1'b0;
			bridge_completed  <= 1'b0;
		end else begin
			// Strobes and completion are single-cycle pulses
			word_rd          <= 1'b0;
			word_wr          <= 1'b0;
			bridge_completed <= 1'b0;

			case (state)
				seq_idle: begin
					if (word_wr) begin
						// Low write half is on the port this cycle, so the write is done
						bridge_completed  <= 1'b1;
						bridge_processing <= 1'b0;
					end else if (accept) begin
						state             <= seq_request;
						is_read           <= bridge_rd_fall;
						word_addr         <= {bridge_addr[25:1], 1'b0};
						bridge_processing <= 1'b1;
					end
				end

				seq_request: begin
					// High half always goes first, at address A
					if (!word_busy) begin
						if (is_read) begin
							word_rd <= 1'b1;
							state   <= seq_read_hi;
						end else begin
							word_wr   <= 1'b1;
							word_data <= wr_latch[31:16];
							state     <= seq_write_lo;
						end
					end
				end

				seq_read_hi: begin
					if (!word_busy) begin
						bridge_rd_data[31:16] <= q_adjusted;
						word_addr             <= word_addr + 26'd2;
						word_rd               <= 1'b1;
						state                 <= seq_read_lo;
					end
				end

				seq_read_lo: begin
					if (!word_busy) begin
						bridge_rd_data[15:0] <= q_adjusted;
						bridge_completed     <= 1'b1;
						bridge_processing    <= 1'b0;
						state                <= seq_idle;
					end
				end

				seq_write_lo: begin
					// Completion follows from idle once this pulse is out
					if (!word_busy) begin
						word_wr   <= 1'b1;
						word_data <= wr_latch[15:0];
						word_addr <= word_addr + 26'd2;
						state     <= seq_idle;
					end
				end

				default: begin
					state <= seq_idle;
				end
			endcase
		end
	end

endmodule

// ==== bridge_synch.sv ====
/*
 * Bridge synchronizer: three flops into clk_sys with
 * single-cycle rise and fall pulses taken from the last two stages
 */

`timescale 1ns/1ps

module bridge_synch #(
	parameter int WIDTH = 1
) (
	input  logic             clk_sys,
	input  logic             reset_l,
	input  logic [WIDTH-1:0] d,
	output logic [WIDTH-1:0] q,
	output logic             rise,
	output logic             fall
);

	logic [WIDTH-1:0] stage_1;
	logic [WIDTH-1:0] stage_2;
	logic [WIDTH-1:0] stage_3;

	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			stage_1 <= '0;
			stage_2 <= '0;
			stage_3 <= '0;
		end else begin
			stage_1 <= d;
			stage_2 <= stage_1;
			stage_3 <= stage_2;
		end
	end

	assign q = stage_3;

	// Edge pulses look at any bit set, which is the strobe itself on 1-bit instances
	assign rise = (|stage_2) & ~(|stage_3);
	assign fall = ~(|stage_2) & (|stage_3);

endmodule

// ==== bridge_ram_pkg.sv ====
/*
 * Bridge to word RAM path: shared address, data and state types
 * plus the reserved register window constant
 */

package bridge_ram_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bridge side, clk_74a domain before synchronization
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Byte address of one 32-bit bridge access
	typedef logic [31:0] bridge_addr_t;

	// One 32-bit bridge data word
	typedef logic [31:0] bridge_data_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Word RAM port, clk_sys domain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// RAM byte address, bit 0 stays zero for half-word accesses
	typedef logic [25:0] word_addr_t;

	// One 16-bit RAM data word
	typedef logic [15:0] word_data_t;

	// Sequencer states
	// seq_write_lo follows the high-half write already on the port
	typedef enum logic [2:0] {
		seq_idle,
		seq_request,
		seq_read_hi,
		seq_read_lo,
		seq_write_lo
	} seq_state_t;

	// Top address byte of the register window, never sent to RAM
	localparam logic [7:0] RESERVED_WINDOW = 8'hF8;

endpackage
